//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing
SIM_FLAGS   = --binary --timing
TOP         = tb_id_stage
RTL_TOP     = id_stage
FILELIST    = compile.f
OBJ_DIR     = obj_dir

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
+incdir+test
logic/id_pkg.sv
logic/inst_decode.sv
logic/operand_forward.sv
logic/id_stage.sv
test/tb_id_stage.sv

//--- logic/id_pkg.sv
/* types, opcode and function codes, and operation enums of the decode stage.
   imported by every decode module and by the testbench model */
`default_nettype none

package id_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] inst_t;

    // operation subtype handed to execute
    typedef enum logic [4:0] {
        aluop_nop,
        aluop_or,
        aluop_and,
        aluop_xor,
        aluop_nor,
        aluop_sll,
        aluop_srl,
        aluop_sra,
        aluop_slt,
        aluop_sltu,
        aluop_add,
        aluop_addu,
        aluop_sub,
        aluop_subu,
        aluop_addi,
        aluop_addiu,
        aluop_movn,
        aluop_movz
    } aluop_t;

    // result class
    typedef enum logic [2:0] {
        alusel_nop,
        alusel_logic,
        alusel_shift,
        alusel_arith,
        alusel_move
    } alusel_t;

    // primary opcodes, bits 31:26
    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_addi    = 6'b001000;
    localparam logic [5:0] op_addiu   = 6'b001001;
    localparam logic [5:0] op_slti    = 6'b001010;
    localparam logic [5:0] op_sltiu   = 6'b001011;
    localparam logic [5:0] op_andi    = 6'b001100;
    localparam logic [5:0] op_ori     = 6'b001101;
    localparam logic [5:0] op_xori    = 6'b001110;
    localparam logic [5:0] op_lui     = 6'b001111;

    // special group function codes, bits 5:0
    localparam logic [5:0] fn_sll  = 6'b000000;
    localparam logic [5:0] fn_srl  = 6'b000010;
    localparam logic [5:0] fn_sra  = 6'b000011;
    localparam logic [5:0] fn_sllv = 6'b000100;
    localparam logic [5:0] fn_srlv = 6'b000110;
    localparam logic [5:0] fn_srav = 6'b000111;
    localparam logic [5:0] fn_movz = 6'b001010;
    localparam logic [5:0] fn_movn = 6'b001011;
    localparam logic [5:0] fn_add  = 6'b100000;
    localparam logic [5:0] fn_addu = 6'b100001;
    localparam logic [5:0] fn_sub  = 6'b100010;
    localparam logic [5:0] fn_subu = 6'b100011;
    localparam logic [5:0] fn_and  = 6'b100100;
    localparam logic [5:0] fn_or   = 6'b100101;
    localparam logic [5:0] fn_xor  = 6'b100110;
    localparam logic [5:0] fn_nor  = 6'b100111;
    localparam logic [5:0] fn_slt  = 6'b101010;
    localparam logic [5:0] fn_sltu = 6'b101011;

    localparam word_t zero_word = 32'h0000_0000;

endpackage

`default_nettype wire

//--- logic/id_stage.sv
/* instruction decode stage top level. register-file requests leave in the
   same cycle, execute-bound values one clock later */
`timescale 1ns/1ps
`default_nettype none

module id_stage import id_pkg::*; (
    input  wire             clk,
    input  wire             rst_i,
    input  wire inst_t      inst_i,
    // register file
    output logic            reg1_read_o,
    output logic            reg2_read_o,
    output reg_addr_t       reg1_addr_o,
    output reg_addr_t       reg2_addr_o,
    input  wire word_t      reg1_data_i,
    input  wire word_t      reg2_data_i,
    // forwarding sources
    input  wire             ex_wreg_i,
    input  wire reg_addr_t  ex_wd_i,
    input  wire word_t      ex_wdata_i,
    input  wire             mem_wreg_i,
    input  wire reg_addr_t  mem_wd_i,
    input  wire word_t      mem_wdata_i,
    // toward execute
    output aluop_t          aluop_o,
    output alusel_t         alusel_o,
    output word_t           reg1_o,
    output word_t           reg2_o,
    output reg_addr_t       wd_o,
    output logic            wreg_o
);

    word_t     dec_imm;
    aluop_t    dec_aluop;
    alusel_t   dec_alusel;
    reg_addr_t dec_wd;
    logic      dec_wreg;

    inst_decode u_decode (
        .inst_i      (inst_i),
        .reg1_read_o (reg1_read_o),
        .reg2_read_o (reg2_read_o),
        .reg1_addr_o (reg1_addr_o),
        .reg2_addr_o (reg2_addr_o),
        .imm_o       (dec_imm),
        .aluop_o     (dec_aluop),
        .alusel_o    (dec_alusel),
        .wd_o        (dec_wd),
        .wreg_o      (dec_wreg)
    );

    // read requests also steer operand selection
    operand_forward u_forward (
        .clk         (clk),
        .rst_i       (rst_i),
        .reg1_read_i (reg1_read_o),
        .reg2_read_i (reg2_read_o),
        .reg1_addr_i (reg1_addr_o),
        .reg2_addr_i (reg2_addr_o),
        .reg1_data_i (reg1_data_i),
        .reg2_data_i (reg2_data_i),
        .imm_i       (dec_imm),
        .aluop_i     (dec_aluop),
        .alusel_i    (dec_alusel),
        .wd_i        (dec_wd),
        .wreg_i      (dec_wreg),
        .ex_wreg_i   (ex_wreg_i),
        .mem_wreg_i  (mem_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .mem_wd_i    (mem_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wdata_i (mem_wdata_i),
        .aluop_o     (aluop_o),
        .alusel_o    (alusel_o),
        .reg1_o      (reg1_o),
        .reg2_o      (reg2_o),
        .wd_o        (wd_o),
        .wreg_o      (wreg_o)
    );

endmodule

`default_nettype wire

//--- logic/inst_decode.sv
/* combinational instruction decoder: register-file read requests, immediate,
   operation, result class, destination and base write enable */
`timescale 1ns/1ps
`default_nettype none

module inst_decode import id_pkg::*; (
    input  wire inst_t     inst_i,
    output logic           reg1_read_o,
    output logic           reg2_read_o,
    output reg_addr_t      reg1_addr_o,
    output reg_addr_t      reg2_addr_o,
    output word_t          imm_o,
    output aluop_t         aluop_o,
    output alusel_t        alusel_o,
    output reg_addr_t      wd_o,
    output logic           wreg_o
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    word_t      imm_zext;
    word_t      imm_upper;
    word_t      imm_sext;
    word_t      imm_shamt;

    assign opcode = inst_i[31:26];
    assign funct  = inst_i[5:0];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];

    // immediate forms
    assign imm_zext  = {16'h0000, inst_i[15:0]};
    assign imm_upper = {inst_i[15:0], 16'h0000};
    assign imm_sext  = {{16{inst_i[15]}}, inst_i[15:0]};
    assign imm_shamt = {27'd0, inst_i[10:6]};

    always_comb begin
        reg1_read_o = 1'b0;
        reg2_read_o = 1'b0;
        reg1_addr_o = rs;
        reg2_addr_o = rt;
        imm_o       = zero_word;
        aluop_o     = aluop_nop;
        alusel_o    = alusel_nop;
        wd_o        = rd;
        wreg_o      = 1'b0;

        case (opcode)
            op_ori: begin
                aluop_o  = aluop_or;
                alusel_o = alusel_logic;
                imm_o    = imm_zext;
            end
            op_andi: begin
                aluop_o  = aluop_and;
                alusel_o = alusel_logic;
                imm_o    = imm_zext;
            end
            op_xori: begin
                aluop_o  = aluop_xor;
                alusel_o = alusel_logic;
                imm_o    = imm_zext;
            end
            // rs is still read and or'ed with the upper-half immediate
            op_lui: begin
                aluop_o  = aluop_or;
                alusel_o = alusel_logic;
                imm_o    = imm_upper;
            end
            // sltiu sign-extends as well
            op_slti: begin
                aluop_o  = aluop_slt;
                alusel_o = alusel_arith;
                imm_o    = imm_sext;
            end
            op_sltiu: begin
                aluop_o  = aluop_sltu;
                alusel_o = alusel_arith;
                imm_o    = imm_sext;
            end
            op_addi: begin
                aluop_o  = aluop_addi;
                alusel_o = alusel_arith;
                imm_o    = imm_sext;
            end
            op_addiu: begin
                aluop_o  = aluop_addiu;
                alusel_o = alusel_arith;
                imm_o    = imm_sext;
            end
            op_special: begin
                case (funct)
                    fn_or:   begin aluop_o = aluop_or;   alusel_o = alusel_logic; end
                    fn_and:  begin aluop_o = aluop_and;  alusel_o = alusel_logic; end
                    fn_xor:  begin aluop_o = aluop_xor;  alusel_o = alusel_logic; end
                    fn_nor:  begin aluop_o = aluop_nor;  alusel_o = alusel_logic; end
                    fn_sll:  begin aluop_o = aluop_sll;  alusel_o = alusel_shift; end
                    fn_srl:  begin aluop_o = aluop_srl;  alusel_o = alusel_shift; end
                    fn_sra:  begin aluop_o = aluop_sra;  alusel_o = alusel_shift; end
                    fn_sllv: begin aluop_o = aluop_sll;  alusel_o = alusel_shift; end
                    fn_srlv: begin aluop_o = aluop_srl;  alusel_o = alusel_shift; end
                    fn_srav: begin aluop_o = aluop_sra;  alusel_o = alusel_shift; end
                    fn_slt:  begin aluop_o = aluop_slt;  alusel_o = alusel_arith; end
                    fn_sltu: begin aluop_o = aluop_sltu; alusel_o = alusel_arith; end
                    fn_add:  begin aluop_o = aluop_add;  alusel_o = alusel_arith; end
                    fn_addu: begin aluop_o = aluop_addu; alusel_o = alusel_arith; end
                    fn_sub:  begin aluop_o = aluop_sub;  alusel_o = alusel_arith; end
                    fn_subu: begin aluop_o = aluop_subu; alusel_o = alusel_arith; end
                    fn_movn: begin aluop_o = aluop_movn; alusel_o = alusel_move;  end
                    fn_movz: begin aluop_o = aluop_movz; alusel_o = alusel_move;  end
                    default: begin
                    end
                endcase
            end
            default: begin
            end
        endcase

        // known i-type reads rs and writes rt
        if (opcode != op_special && alusel_o != alusel_nop) begin
            reg1_read_o = 1'b1;
            wd_o        = rt;
            wreg_o      = 1'b1;
        end

        // known r-type reads both ports and writes rd
        if (opcode == op_special && alusel_o != alusel_nop) begin
            reg1_read_o = 1'b1;
            reg2_read_o = 1'b1;
            wreg_o      = 1'b1;
            // shift by shamt leaves port 1 to the immediate
            if (funct == fn_sll || funct == fn_srl || funct == fn_sra) begin
                reg1_read_o = 1'b0;
                imm_o       = imm_shamt;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/operand_forward.sv
/* operand selection with execute and memory forwarding, conditional-move
   write gating, and the registered boundary toward execute */
`timescale 1ns/1ps
`default_nettype none

module operand_forward import id_pkg::*; (
    input  wire             clk,
    input  wire             rst_i,
    input  wire             reg1_read_i,
    input  wire             reg2_read_i,
    input  wire reg_addr_t  reg1_addr_i,
    input  wire reg_addr_t  reg2_addr_i,
    input  wire word_t      reg1_data_i,
    input  wire word_t      reg2_data_i,
    input  wire word_t      imm_i,
    input  wire aluop_t     aluop_i,
    input  wire alusel_t    alusel_i,
    input  wire reg_addr_t  wd_i,
    input  wire             wreg_i,
    input  wire             ex_wreg_i,
    input  wire             mem_wreg_i,
    input  wire reg_addr_t  ex_wd_i,
    input  wire reg_addr_t  mem_wd_i,
    input  wire word_t      ex_wdata_i,
    input  wire word_t      mem_wdata_i,
    output aluop_t          aluop_o,
    output alusel_t         alusel_o,
    output word_t           reg1_o,
    output word_t           reg2_o,
    output reg_addr_t       wd_o,
    output logic            wreg_o
);

    word_t opnd1;
    word_t opnd2;
    logic  wreg_gated;

    // execute beats memory beats register file; unread port takes imm
    function automatic word_t pick_operand(input logic rd_en, input reg_addr_t addr,
                                           input word_t rf_data);
        word_t result;
        if (rd_en && ex_wreg_i && ex_wd_i == addr) begin
            result = ex_wdata_i;
        end else if (rd_en && mem_wreg_i && mem_wd_i == addr) begin
            result = mem_wdata_i;
        end else if (rd_en) begin
            result = rf_data;
        end else begin
            result = imm_i;
        end
        return result;
    endfunction

    assign opnd1 = pick_operand(reg1_read_i, reg1_addr_i, reg1_data_i);
    assign opnd2 = pick_operand(reg2_read_i, reg2_addr_i, reg2_data_i);

    // conditional moves look at the forwarded rt value
    always_comb begin
        case (aluop_i)
            aluop_movn: wreg_gated = wreg_i && (opnd2 != zero_word);
            aluop_movz: wreg_gated = wreg_i && (opnd2 == zero_word);
            default:    wreg_gated = wreg_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            aluop_o  <= aluop_nop;
            alusel_o <= alusel_nop;
            reg1_o   <= zero_word;
            reg2_o   <= zero_word;
            wd_o     <= '0;
            wreg_o   <= 1'b0;
        end else begin
            aluop_o  <= aluop_i;
            alusel_o <= alusel_i;
            reg1_o   <= opnd1;
            reg2_o   <= opnd2;
            wd_o     <= wd_i;
            wreg_o   <= wreg_gated;
        end
    end

endmodule

`default_nettype wire

//--- test/id_model.svh
/* reference model of decode, operand forwarding and the conditional-move
   write gate. included inside the testbench module */
`ifndef ID_MODEL_SVH
`define ID_MODEL_SVH

typedef struct packed {
    logic      rd1;
    logic      rd2;
    reg_addr_t a1;
    reg_addr_t a2;
    word_t     imm;
    aluop_t    op;
    alusel_t   sel;
    reg_addr_t wd;
    logic      wreg;
} dec_ref_t;

// result class follows the operation
function automatic alusel_t class_of(input aluop_t op);
    case (op)
        aluop_nop: return alusel_nop;
        aluop_or, aluop_and, aluop_xor, aluop_nor: return alusel_logic;
        aluop_sll, aluop_srl, aluop_sra: return alusel_shift;
        aluop_movn, aluop_movz: return alusel_move;
        default: return alusel_arith;
    endcase
endfunction

function automatic dec_ref_t decode_ref(input inst_t inst);
    dec_ref_t   d;
    logic [5:0] op;
    logic [5:0] fn;
    op     = inst[31:26];
    fn     = inst[5:0];
    d.rd1  = 1'b0;
    d.rd2  = 1'b0;
    d.a1   = inst[25:21];
    d.a2   = inst[20:16];
    d.imm  = zero_word;
    d.wd   = inst[15:11];
    d.wreg = 1'b0;
    if (op != op_special) begin
        case (op)
            op_ori, op_lui: d.op = aluop_or;
            op_andi: d.op = aluop_and;
            op_xori: d.op = aluop_xor;
            op_slti: d.op = aluop_slt;
            op_sltiu: d.op = aluop_sltu;
            op_addi: d.op = aluop_addi;
            op_addiu: d.op = aluop_addiu;
            default: d.op = aluop_nop;
        endcase
        if (d.op != aluop_nop) begin
            d.rd1  = 1'b1;
            d.wd   = inst[20:16];
            d.wreg = 1'b1;
        end
        if (op == op_lui) begin
            d.imm = {inst[15:0], 16'h0000};
        end else if (op inside {op_ori, op_andi, op_xori}) begin
            d.imm = {16'h0000, inst[15:0]};
        end else if (d.op != aluop_nop) begin
            d.imm = {{16{inst[15]}}, inst[15:0]};
        end
    end else begin
        case (fn)
            fn_or: d.op = aluop_or;
            fn_and: d.op = aluop_and;
            fn_xor: d.op = aluop_xor;
            fn_nor: d.op = aluop_nor;
            fn_sll, fn_sllv: d.op = aluop_sll;
            fn_srl, fn_srlv: d.op = aluop_srl;
            fn_sra, fn_srav: d.op = aluop_sra;
            fn_slt: d.op = aluop_slt;
            fn_sltu: d.op = aluop_sltu;
            fn_add: d.op = aluop_add;
            fn_addu: d.op = aluop_addu;
            fn_sub: d.op = aluop_sub;
            fn_subu: d.op = aluop_subu;
            fn_movn: d.op = aluop_movn;
            fn_movz: d.op = aluop_movz;
            default: d.op = aluop_nop;
        endcase
        if (d.op != aluop_nop) begin
            d.rd1  = 1'b1;
            d.rd2  = 1'b1;
            d.wreg = 1'b1;
        end
        // shift by shamt reads port 2 only
        if (fn inside {fn_sll, fn_srl, fn_sra}) begin
            d.rd1 = 1'b0;
            d.imm = {27'd0, inst[10:6]};
        end
    end
    d.sel = class_of(d.op);
    return d;
endfunction

// forwarding values come from the testbench's driven inputs
function automatic word_t operand_ref(input logic rd, input reg_addr_t addr,
                                      input word_t rf, input word_t imm);
    if (!rd) return imm;
    if (ex_wreg && ex_wd == addr) return ex_wdata;
    if (mem_wreg && mem_wd == addr) return mem_wdata;
    return rf;
endfunction

function automatic logic wreg_ref(input aluop_t op, input logic base, input word_t opnd2);
    case (op)
        aluop_movn: return base && (opnd2 != zero_word);
        aluop_movz: return base && (opnd2 == zero_word);
        default: return base;
    endcase
endfunction

`endif

//--- test/tb_id_stage.sv
/* random-stimulus testbench for the decode stage. inputs change on the
   falling edge and are checked against the model one cycle later */
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage import id_pkg::*; ();

    localparam int num_tests    = 2000;
    localparam int clk_period   = 4;
    localparam int reset_cycles = 8;
    localparam logic [31:0] seed_init = 32'h36f5;

    // kept encodings for the random instruction mix
    localparam logic [7:0][5:0] kept_ops = {op_ori, op_andi, op_xori, op_lui,
                                            op_slti, op_sltiu, op_addi, op_addiu};
    localparam logic [17:0][5:0] kept_fns = {fn_or, fn_and, fn_xor, fn_nor, fn_sll, fn_srl,
                                             fn_sra, fn_sllv, fn_srlv, fn_srav, fn_slt,
                                             fn_sltu, fn_add, fn_addu, fn_sub, fn_subu,
                                             fn_movn, fn_movz};

    logic      clk;
    logic      rst;
    inst_t     inst;
    word_t     reg1_data;
    word_t     reg2_data;
    logic      ex_wreg;
    reg_addr_t ex_wd;
    word_t     ex_wdata;
    logic      mem_wreg;
    reg_addr_t mem_wd;
    word_t     mem_wdata;
    logic      reg1_read;
    logic      reg2_read;
    reg_addr_t reg1_addr;
    reg_addr_t reg2_addr;
    aluop_t    aluop;
    alusel_t   alusel;
    word_t     reg1;
    word_t     reg2;
    reg_addr_t wd;
    logic      wreg;

    integer    seed;
    int        errors;
    int        checks;
    aluop_t    exp_aluop;
    alusel_t   exp_alusel;
    word_t     exp_reg1;
    word_t     exp_reg2;
    reg_addr_t exp_wd;
    logic      exp_wreg;

    `include "id_model.svh"

    id_stage dut0 (
        .clk(clk), .rst_i(rst), .inst_i(inst),
        .reg1_read_o(reg1_read), .reg2_read_o(reg2_read),
        .reg1_addr_o(reg1_addr), .reg2_addr_o(reg2_addr),
        .reg1_data_i(reg1_data), .reg2_data_i(reg2_data),
        .ex_wreg_i(ex_wreg), .ex_wd_i(ex_wd), .ex_wdata_i(ex_wdata),
        .mem_wreg_i(mem_wreg), .mem_wd_i(mem_wd), .mem_wdata_i(mem_wdata),
        .aluop_o(aluop), .alusel_o(alusel), .reg1_o(reg1), .reg2_o(reg2),
        .wd_o(wd), .wreg_o(wreg)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // zero now and then so movn and movz see both outcomes
    function automatic word_t rnd_word();
        logic [31:0] r;
        r = $random(seed);
        if (r[2:0] == 3'd0) return zero_word;
        return $random(seed);
    endfunction

    function automatic reg_addr_t fwd_addr();
        logic [31:0] r;
        r = $random(seed);
        if (r[0]) return r[1] ? inst[25:21] : inst[20:16];
        return r[8:4];
    endfunction

    task automatic drive_inputs();
        logic [31:0] r;
        logic [31:0] f;
        r = $random(seed);
        f = $random(seed);
        if (r[3:0] == 4'd0) begin
            inst = f;
        end else if (r[3:0] < 4'd7) begin
            inst = {kept_ops[r[6:4]], f[25:0]};
        end else if (r[20:18] == 3'd0) begin
            // special group with any function code, mostly unknown ones
            inst = {op_special, f[25:0]};
        end else begin
            inst = {op_special, f[25:6], kept_fns[5'(r[15:8] % 8'd18)]};
        end
        reg1_data = rnd_word();
        reg2_data = rnd_word();
        ex_wreg   = r[16];
        mem_wreg  = r[17];
        ex_wd     = fwd_addr();
        mem_wd    = fwd_addr();
        ex_wdata  = rnd_word();
        mem_wdata = rnd_word();
    endtask

    task automatic save_expected();
        dec_ref_t d;
        word_t    o1;
        word_t    o2;
        d  = decode_ref(inst);
        o1 = operand_ref(d.rd1, d.a1, reg1_data, d.imm);
        o2 = operand_ref(d.rd2, d.a2, reg2_data, d.imm);
        exp_aluop  = rst ? aluop_nop : d.op;
        exp_alusel = rst ? alusel_nop : d.sel;
        exp_reg1   = rst ? zero_word : o1;
        exp_reg2   = rst ? zero_word : o2;
        exp_wd     = rst ? 5'd0 : d.wd;
        exp_wreg   = rst ? 1'b0 : wreg_ref(d.op, d.wreg, o2);
    endtask

    task automatic check_outputs();
        dec_ref_t d;
        d = decode_ref(inst);
        check_value("reg1_read_o", 32'(reg1_read), 32'(d.rd1));
        check_value("reg2_read_o", 32'(reg2_read), 32'(d.rd2));
        check_value("reg1_addr_o", 32'(reg1_addr), 32'(d.a1));
        check_value("reg2_addr_o", 32'(reg2_addr), 32'(d.a2));
        check_value("aluop_o", 32'(aluop), 32'(exp_aluop));
        check_value("alusel_o", 32'(alusel), 32'(exp_alusel));
        check_value("reg1_o", reg1, exp_reg1);
        check_value("reg2_o", reg2, exp_reg2);
        check_value("wd_o", 32'(wd), 32'(exp_wd));
        check_value("wreg_o", 32'(wreg), 32'(exp_wreg));
    endtask

    initial begin
        seed      = seed_init;
        errors    = 0;
        checks    = 0;
        clk       = 1'b0;
        rst       = 1'b1;
        inst      = '0;
        reg1_data = '0;
        reg2_data = '0;
        ex_wreg   = 1'b0;
        ex_wd     = '0;
        ex_wdata  = '0;
        mem_wreg  = 1'b0;
        mem_wd    = '0;
        mem_wdata = '0;
        save_expected();
        // first edge at 2 ns already sees reset
        for (int i = 0; i < reset_cycles + num_tests; i++) begin
            @(negedge clk);
            check_outputs();
            rst = (i < reset_cycles - 1);
            drive_inputs();
            save_expected();
        end
        @(negedge clk);
        check_outputs();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #((num_tests + 20) * clk_period * 2);
        $display("timeout: the stimulus loop did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
